//--- list.f
hdl/clock_time_pkg.sv
hdl/seg_display_pkg.sv
hdl/clock_time_if.sv
hdl/tick_divider.sv
hdl/wrap_counter.sv
hdl/time_counter_chain.sv
hdl/display_encoder.sv
hdl/digital_clock_top.sv
dv/digital_clock_tb.sv

//--- dv/digital_clock_tb.sv
`timescale 1ns/10ps

module digital_clock_tb;

    localparam int clk_half       = 4;              // 8 ns period
    localparam int tick_div       = 4;              // short second for simulation
    localparam int reset_cycles   = 5;
    localparam int day_secs       = 24 * 60 * 60;
    localparam int run_cycles     = (day_secs + 130) * tick_div + tick_div;
    localparam int max_offset     = 256;            // range of the mid-run reset point
    localparam int rerun_cycles   = 130 * tick_div;
    localparam int test_cycles    = run_cycles + max_offset + reset_cycles + rerun_cycles;
    localparam int timeout_cycles = 400_000;        // test_cycles plus roughly 15 percent

    logic                  clk;
    logic                  rst = 1'b1;
    seg_display_pkg::seg_t seg_sec_units;
    seg_display_pkg::seg_t seg_sec_tens;
    seg_display_pkg::seg_t seg_min_units;
    seg_display_pkg::seg_t seg_min_tens;
    seg_display_pkg::seg_t seg_hour_units;
    seg_display_pkg::seg_t seg_hour_tens;
    logic                  day_pulse;

    integer seed = 32'hf83b3132;

    // reference model state
    int unsigned edge_cnt;      // rising edges since reset release
    logic        exp_tick;
    int          exp_h;
    int          exp_m;
    int          exp_s;

    seg_display_pkg::seg_t exp_sec_units;
    seg_display_pkg::seg_t exp_sec_tens;
    seg_display_pkg::seg_t exp_min_units;
    seg_display_pkg::seg_t exp_min_tens;
    seg_display_pkg::seg_t exp_hour_units;
    seg_display_pkg::seg_t exp_hour_tens;
    logic                  exp_day;

    digital_clock_top #(
        .TICK_DIV (tick_div)
    ) digital_clock_top_i (
        .clk            (clk),
        .rst            (rst),
        .seg_sec_units  (seg_sec_units),
        .seg_sec_tens   (seg_sec_tens),
        .seg_min_units  (seg_min_units),
        .seg_min_tens   (seg_min_tens),
        .seg_hour_units (seg_hour_units),
        .seg_hour_tens  (seg_hour_tens),
        .day_pulse      (day_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string name, input logic [6:0] expected,
                                   input logic [6:0] actual);
        stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h",
                                    name, expected, actual));
    endtask

    // async reset must clear the display before any clock edge
    task automatic check_display_cleared();
        seg_display_pkg::seg_t zero_seg;
        zero_seg = seg_display_pkg::seg_encode(4'd0);
        assert (seg_sec_units == zero_seg)
            else report_mismatch("seg_sec_units", zero_seg, seg_sec_units);
        assert (seg_sec_tens == zero_seg)
            else report_mismatch("seg_sec_tens", zero_seg, seg_sec_tens);
        assert (seg_min_units == zero_seg)
            else report_mismatch("seg_min_units", zero_seg, seg_min_units);
        assert (seg_min_tens == zero_seg)
            else report_mismatch("seg_min_tens", zero_seg, seg_min_tens);
        assert (seg_hour_units == zero_seg)
            else report_mismatch("seg_hour_units", zero_seg, seg_hour_units);
        assert (seg_hour_tens == zero_seg)
            else report_mismatch("seg_hour_tens", zero_seg, seg_hour_tens);
        assert (day_pulse == 1'b0)
            else report_mismatch("day_pulse", 7'd0, {6'd0, day_pulse});
    endtask

    task automatic reset_dut();
        rst <= 1'b0;
        #1;
        check_display_cleared();
        repeat (reset_cycles) @(negedge clk);
        rst <= 1'b1;
    endtask

    // tick on the tick_div-th edge after release, then every tick_div edges
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            edge_cnt <= 0;
            exp_tick <= 1'b0;
            exp_h    <= 0;
            exp_m    <= 0;
            exp_s    <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
            exp_tick <= ((edge_cnt + 1) % tick_div) == 0;
            if (exp_tick) begin
                if (exp_s < 59) begin
                    exp_s <= exp_s + 1;
                end else begin
                    exp_s <= 0;
                    if (exp_m < 59) begin
                        exp_m <= exp_m + 1;
                    end else begin
                        exp_m <= 0;
                        exp_h <= (exp_h < 23) ? exp_h + 1 : 0;  // midnight wrap
                    end
                end
            end
        end
    end

    assign exp_sec_units  = seg_display_pkg::seg_encode(4'(exp_s % 10));
    assign exp_sec_tens   = seg_display_pkg::seg_encode(4'(exp_s / 10));
    assign exp_min_units  = seg_display_pkg::seg_encode(4'(exp_m % 10));
    assign exp_min_tens   = seg_display_pkg::seg_encode(4'(exp_m / 10));
    assign exp_hour_units = seg_display_pkg::seg_encode(4'(exp_h % 10));
    assign exp_hour_tens  = seg_display_pkg::seg_encode(4'(exp_h / 10));
    assign exp_day        = exp_tick && exp_h == 23 && exp_m == 59 && exp_s == 59;

    sec_units_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_sec_units == exp_sec_units)
        else report_mismatch("seg_sec_units", $sampled(exp_sec_units), $sampled(seg_sec_units));
    sec_tens_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_sec_tens == exp_sec_tens)
        else report_mismatch("seg_sec_tens", $sampled(exp_sec_tens), $sampled(seg_sec_tens));
    min_units_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_min_units == exp_min_units)
        else report_mismatch("seg_min_units", $sampled(exp_min_units), $sampled(seg_min_units));
    min_tens_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_min_tens == exp_min_tens)
        else report_mismatch("seg_min_tens", $sampled(exp_min_tens), $sampled(seg_min_tens));
    hour_units_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_hour_units == exp_hour_units)
        else report_mismatch("seg_hour_units", $sampled(exp_hour_units),
                             $sampled(seg_hour_units));
    hour_tens_ok: assert property (@(posedge clk) disable iff (!rst)
            seg_hour_tens == exp_hour_tens)
        else report_mismatch("seg_hour_tens", $sampled(exp_hour_tens), $sampled(seg_hour_tens));
    day_pulse_ok: assert property (@(posedge clk) disable iff (!rst)
            day_pulse == exp_day)
        else report_mismatch("day_pulse", {6'd0, $sampled(exp_day)}, {6'd0, $sampled(day_pulse)});

    // units digit may only move in the cycle after a tick
    sec_step_ok: assert property (@(posedge clk) disable iff (!rst)
            $changed(seg_sec_units) |-> $past(exp_tick))
        else stop_with_failure("seconds units digit changed without a tick one cycle before");

    initial begin : stimulus
        int unsigned offset;
        reset_dut();
        repeat (run_cycles) @(negedge clk);    // one day plus 130 s
        offset = $unsigned($random(seed)) % max_offset;
        repeat (offset) @(negedge clk);
        reset_dut();                            // mid-run reset
        repeat (rerun_cycles) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        @(posedge rst);
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_failure($sformatf("timeout, run not finished after %0d cycles (test needs %0d)",
                                    timeout_cycles, test_cycles));
    end

endmodule

//--- hdl/digital_clock_top.sv
`timescale 1ns/10ps

module digital_clock_top #(
    parameter int TICK_DIV = 50_000_000     // clk cycles per second
) (
    input  logic                              clk,
    input  logic                              rst,
    output logic [seg_display_pkg::seg_w-1:0] seg_sec_units,
    output logic [seg_display_pkg::seg_w-1:0] seg_sec_tens,
    output logic [seg_display_pkg::seg_w-1:0] seg_min_units,
    output logic [seg_display_pkg::seg_w-1:0] seg_min_tens,
    output logic [seg_display_pkg::seg_w-1:0] seg_hour_units,
    output logic [seg_display_pkg::seg_w-1:0] seg_hour_tens,
    output logic                              day_pulse
);

    logic tick;     // one cycle per second

    clock_time_if time_bus ();

    tick_divider #(
        .TICK_DIV (TICK_DIV)
    ) tick_div_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    time_counter_chain time_chain_i (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .time_bus (time_bus.producer)
    );

    display_encoder disp_enc_i (
        .time_bus   (time_bus.consumer),
        .sec_units  (seg_sec_units),
        .sec_tens   (seg_sec_tens),
        .min_units  (seg_min_units),
        .min_tens   (seg_min_tens),
        .hour_units (seg_hour_units),
        .hour_tens  (seg_hour_tens)
    );

    // midnight rollover out to the pin
    assign day_pulse = time_bus.day_pulse;

endmodule

//--- hdl/display_encoder.sv
`timescale 1ns/10ps

module display_encoder (
    clock_time_if.consumer         time_bus,
    output seg_display_pkg::seg_t  sec_units,
    output seg_display_pkg::seg_t  sec_tens,
    output seg_display_pkg::seg_t  min_units,
    output seg_display_pkg::seg_t  min_tens,
    output seg_display_pkg::seg_t  hour_units,
    output seg_display_pkg::seg_t  hour_tens
);

    typedef logic [seg_display_pkg::digit_w-1:0] digit_t;

    // fields only go up to 59, so tens fits in one digit
    function automatic digit_t tens_of(input clock_time_pkg::time_field_t field);
        return digit_t'(field / 10);
    endfunction

    function automatic digit_t units_of(input clock_time_pkg::time_field_t field);
        return digit_t'(field % 10);
    endfunction

    digit_t sec_u_d;
    digit_t sec_t_d;
    digit_t min_u_d;
    digit_t min_t_d;
    digit_t hour_u_d;
    digit_t hour_t_d;

    // split into decimal digits
    assign sec_u_d  = units_of(time_bus.seconds);
    assign sec_t_d  = tens_of(time_bus.seconds);
    assign min_u_d  = units_of(time_bus.minutes);
    assign min_t_d  = tens_of(time_bus.minutes);
    assign hour_u_d = units_of(time_bus.hours);
    assign hour_t_d = tens_of(time_bus.hours);     // 0..2

    // digit to segments, no register in the path
    assign sec_units  = seg_display_pkg::seg_encode(sec_u_d);
    assign sec_tens   = seg_display_pkg::seg_encode(sec_t_d);
    assign min_units  = seg_display_pkg::seg_encode(min_u_d);
    assign min_tens   = seg_display_pkg::seg_encode(min_t_d);
    assign hour_units = seg_display_pkg::seg_encode(hour_u_d);
    assign hour_tens  = seg_display_pkg::seg_encode(hour_t_d);

endmodule

//--- hdl/time_counter_chain.sv
`timescale 1ns/10ps

module time_counter_chain (
    input logic           clk,
    input logic           rst,
    input logic           tick,
    clock_time_if.producer time_bus
);

    logic sec_carry;    // 59 -> 0 seconds
    logic min_carry;    // 59:59 -> 00:00
    logic hour_carry;   // 23:59:59 -> 00:00:00

    // seconds, stepped by the divider tick
    wrap_counter #(
        .MODULUS (clock_time_pkg::sec_mod)
    ) sec_cnt (
        .clk    (clk),
        .rst    (rst),
        .enable (tick),
        .value  (time_bus.seconds),
        .carry  (sec_carry)
    );

    // minutes
    wrap_counter #(
        .MODULUS (clock_time_pkg::min_mod)
    ) min_cnt (
        .clk    (clk),
        .rst    (rst),
        .enable (sec_carry),
        .value  (time_bus.minutes),
        .carry  (min_carry)
    );

    // hours
    wrap_counter #(
        .MODULUS (clock_time_pkg::hour_mod)
    ) hour_cnt (
        .clk    (clk),
        .rst    (rst),
        .enable (min_carry),
        .value  (time_bus.hours),
        .carry  (hour_carry)
    );

    // carries are combinational through the chain, so this lines up with tick
    assign time_bus.day_pulse = hour_carry;

endmodule

//--- hdl/wrap_counter.sv
`timescale 1ns/10ps

module wrap_counter #(
    parameter int MODULUS = 60
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    output clock_time_pkg::time_field_t value,
    output logic                        carry
);

    localparam clock_time_pkg::time_field_t last_val =
        clock_time_pkg::time_field_t'(MODULUS - 1);

    logic at_last;

    assign at_last = (value == last_val);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            value <= '0;
        end else if (enable) begin
            if (at_last) begin
                value <= '0;                // wrap
            end else begin
                value <= value + 1'b1;
            end
        end
    end

    // same cycle as the enable that causes the wrap
    assign carry = enable && at_last;

endmodule

//--- hdl/tick_divider.sv
`timescale 1ns/10ps

module tick_divider #(
    parameter int TICK_DIV = 50_000_000     // clk cycles per second
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // just wide enough to hold TICK_DIV-1
    localparam int cnt_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(TICK_DIV - 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            if (count == cnt_last) begin
                count <= '0;
                tick  <= 1'b1;              // one cycle per wrap
            end else begin
                count <= count + 1'b1;
                tick  <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/clock_time_if.sv
`timescale 1ns/10ps

interface clock_time_if;

    clock_time_pkg::time_field_t seconds;   // 0..59
    clock_time_pkg::time_field_t minutes;   // 0..59
    clock_time_pkg::time_field_t hours;     // 0..23
    logic                        day_pulse; // one cycle at midnight rollover

    // counter side
    modport producer (
        output seconds,
        output minutes,
        output hours,
        output day_pulse
    );

    // display and top level side
    modport consumer (
        input seconds,
        input minutes,
        input hours,
        input day_pulse
    );

endinterface

//--- hdl/seg_display_pkg.sv
package seg_display_pkg;

    localparam int digit_w = 4;     // one decimal digit
    localparam int seg_w   = 7;     // segments a..g

    // bit 0 = a ... bit 6 = g, active high
    typedef logic [seg_w-1:0] seg_t;

    // decimal digit to segment pattern, anything above 9 blanks the digit
    function automatic seg_t seg_encode(input logic [digit_w-1:0] digit);
        seg_t seg;
        case (digit)
            4'd0:    seg = 7'b011_1111;   // a b c d e f
            4'd1:    seg = 7'b000_0110;   // b c
            4'd2:    seg = 7'b101_1011;   // a b d e g
            4'd3:    seg = 7'b100_1111;   // a b c d g
            4'd4:    seg = 7'b110_0110;   // b c f g
            4'd5:    seg = 7'b110_1101;   // a c d f g
            4'd6:    seg = 7'b111_1101;   // a c d e f g
            4'd7:    seg = 7'b000_0111;   // a b c
            4'd8:    seg = 7'b111_1111;   // all on
            4'd9:    seg = 7'b110_1111;   // a b c d f g
            default: seg = '0;            // out of range, blank
        endcase
        return seg;
    endfunction

endpackage

//--- hdl/clock_time_pkg.sv
package clock_time_pkg;

    // width of one time field, enough for 0..59
    localparam int field_w = 6;

    // one field value: seconds, minutes or hours
    typedef logic [field_w-1:0] time_field_t;

    // counter modulus per field
    localparam int sec_mod  = 60;   // seconds wrap 59 -> 0
    localparam int min_mod  = 60;   // minutes wrap 59 -> 0
    localparam int hour_mod = 24;   // hours wrap 23 -> 0

endpackage
